// File: Bender.yml
package:
  name: matrix_frame

export_include_dirs:
  - .

sources:
  - matrix_pkg.sv
  - cmd_decoder.sv
  - frame_loader.sv
  - frame_buffer.sv
  - matrix_frame_top.sv
  - target: test
    files:
      - matrix_frame_sva.sv
      - tb_matrix_frame.sv

// File: cmd_decoder.sv
/* Command byte decoder */

`timescale 1ns/1ps

`include "matrix_defs.svh"

module cmd_decoder
    import matrix_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  byte_t byte_in,
    input  logic  byte_valid,
    input  logic  load_done,
    output logic  load_enable,
    output byte_t load_data,
    output logic  busy,
    output logic  frame_done,
    output logic  bad_cmd
);

    decoder_state_t state;

    logic is_load_cmd;

    assign is_load_cmd = (byte_in == `CMD_LOAD_FRAME);

    // a frame is in progress until the loader reports completion.
    assign busy = (state == DEC_PAYLOAD);

    // ====================
    // command FSM
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= DEC_IDLE;
            load_enable <= 1'b0;
            frame_done  <= 1'b0;
            bad_cmd     <= 1'b0;
        end else begin
            // pulses default low.
            load_enable <= 1'b0;
            frame_done  <= 1'b0;
            bad_cmd     <= 1'b0;

            case (state)
                DEC_IDLE: begin
                    if (byte_valid) begin
                        if (is_load_cmd) begin
                            state <= DEC_PAYLOAD;
                        end else begin
                            // unknown opcode, byte is dropped.
                            bad_cmd <= 1'b1;
                        end
                    end
                end

                DEC_PAYLOAD: begin
                    if (load_done) begin
                        frame_done <= 1'b1;
                        state      <= DEC_IDLE;
                    end else if (byte_valid) begin
                        load_enable <= 1'b1;
                    end
                end

                default: begin
                    state <= DEC_IDLE;
                end
            endcase
        end
    end

    // ====================
    // payload register
    // ====================
    // captured alongside the strobe so the loader sees both
    // on the same edge.
    always_ff @(posedge clk) begin
        if (byte_valid) begin
            load_data <= byte_in;
        end
    end

endmodule

// File: frame_buffer.sv
/* Frame RAM */

`timescale 1ns/1ps

`include "matrix_defs.svh"

module frame_buffer
    import matrix_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  row_t  row,
    input  col_t  column,
    input  pix_t  pixel,
    input  byte_t wr_data,
    input  logic  write_active,
    input  logic  access_toggle,
    input  logic  rd_en,
    input  row_t  rd_row,
    input  col_t  rd_column,
    input  pix_t  rd_pixel,
    output byte_t rd_data,
    output logic  rd_valid
);

    byte_t mem [`MATRIX_FRAME_BYTES];

    logic      toggle_seen;
    logic      write_req;
    ram_addr_t wr_addr;
    ram_addr_t rd_addr;

    // row-major, colour bytes packed per pixel.
    function automatic ram_addr_t linear_addr(row_t r, col_t c, pix_t p);
        return ram_addr_t'((r * `MATRIX_WIDTH + c) * `MATRIX_BPP + p);
    endfunction

    assign wr_addr = linear_addr(row, column, pixel);
    assign rd_addr = linear_addr(rd_row, rd_column, rd_pixel);

    // ====================
    // write side
    // ====================
    // each toggle edge from the loader is one byte.
    always_ff @(posedge clk) begin
        if (reset) begin
            toggle_seen <= 1'b0;
        end else begin
            toggle_seen <= access_toggle;
        end
    end

    assign write_req = write_active && (access_toggle != toggle_seen);

    always_ff @(posedge clk) begin
        if (write_req) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // ====================
    // read side
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// File: frame_loader.sv
/* Frame write sequencer */

`timescale 1ns/1ps

`include "matrix_defs.svh"

module frame_loader
    import matrix_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  load_enable,
    input  byte_t load_data,
    output row_t  row,
    output col_t  column,
    output pix_t  pixel,
    output byte_t wr_data,
    output logic  write_active,
    output logic  access_toggle,
    output logic  load_done
);

    // top corner of the frame, where the walk starts.
    localparam row_t ROW_MAX = row_t'(`MATRIX_HEIGHT - 1);
    localparam col_t COL_MAX = col_t'(`MATRIX_WIDTH - 1);
    localparam pix_t PIX_MAX = pix_t'(`MATRIX_BPP - 1);

    loader_state_t state;

    row_t next_row;
    col_t next_column;
    pix_t next_pixel;
    logic last_byte;

    // ====================
    // down counters
    // ====================
    // pixel counts fastest, then column, then row.
    always_comb begin
        next_row    = row;
        next_column = column;
        next_pixel  = pixel;
        if (pixel != '0) begin
            next_pixel = pixel - 1'b1;
        end else begin
            next_pixel = PIX_MAX;
            if (column != '0) begin
                next_column = column - 1'b1;
            end else begin
                next_column = COL_MAX;
                next_row    = row - 1'b1;
            end
        end
    end

    // next byte lands on the zero corner.
    assign last_byte = (next_row == '0) && (next_column == '0) && (next_pixel == '0);

    // ====================
    // sequencer FSM
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= LOAD_PRIME;
            row           <= '0;
            column        <= '0;
            pixel         <= '0;
            write_active  <= 1'b0;
            access_toggle <= 1'b0;
            load_done     <= 1'b0;
        end else begin
            case (state)
                LOAD_PRIME: begin
                    if (load_enable) begin
                        row           <= ROW_MAX;
                        column        <= COL_MAX;
                        pixel         <= PIX_MAX;
                        write_active  <= 1'b1;
                        access_toggle <= ~access_toggle;
                        state         <= LOAD_STREAM;
                    end
                end

                LOAD_STREAM: begin
                    if (load_enable) begin
                        row           <= next_row;
                        column        <= next_column;
                        pixel         <= next_pixel;
                        access_toggle <= ~access_toggle;
                        if (last_byte) begin
                            state <= LOAD_DONE;
                        end
                    end
                end

                LOAD_DONE: begin
                    // hold one cycle so the buffer sees the final toggle.
                    if (!load_done) begin
                        load_done    <= 1'b1;
                        write_active <= 1'b0;
                    end else begin
                        load_done <= 1'b0;
                        state     <= LOAD_PRIME;
                    end
                end

                default: begin
                    state <= LOAD_PRIME;
                end
            endcase
        end
    end

    // write data follows each accepted byte.
    always_ff @(posedge clk) begin
        if (load_enable && (state != LOAD_DONE)) begin
            wr_data <= load_data;
        end
    end

endmodule

// File: matrix_defs.svh
/* LED matrix frame definitions */

`ifndef MATRIX_DEFS_SVH
`define MATRIX_DEFS_SVH

// ====================
// frame geometry.
// ====================
`define MATRIX_WIDTH   4
`define MATRIX_HEIGHT  4
`define MATRIX_BPP     3

// counter widths for row, column and colour byte.
`define MATRIX_ROW_BITS  2
`define MATRIX_COL_BITS  2
`define MATRIX_PIX_BITS  2

// payload size and linear RAM address width.
`define MATRIX_FRAME_BYTES  (`MATRIX_WIDTH * `MATRIX_HEIGHT * `MATRIX_BPP)
`define MATRIX_ADDR_BITS    6

// ====================
// command codes.
// ====================
`define CMD_LOAD_FRAME  8'h01

`endif

// File: matrix_frame_sva.sv
/* Loader and buffer assertions */

`timescale 1ns/1ps

module matrix_frame_sva (
    input logic clk,
    input logic reset,
    input logic write_active,
    input logic access_toggle,
    input logic load_done,
    input logic rd_en,
    input logic rd_valid
);

    int assert_errors = 0;

    // a toggle edge outside a frame would be a stray write.
    toggle_in_window: assert property (@(posedge clk) disable iff (reset)
        $changed(access_toggle) |-> write_active)
    else begin
        $error("access_toggle changed while write_active was low");
        assert_errors++;
    end

    read_valid_rise: assert property (@(posedge clk) disable iff (reset)
        rd_en |=> rd_valid)
    else begin
        $error("rd_valid missing one cycle after rd_en");
        assert_errors++;
    end

    read_valid_idle: assert property (@(posedge clk) disable iff (reset)
        !rd_en |=> !rd_valid)
    else begin
        $error("rd_valid high without a read");
        assert_errors++;
    end

    done_single_cycle: assert property (@(posedge clk) disable iff (reset)
        load_done |=> !load_done)
    else begin
        $error("load_done held longer than one cycle");
        assert_errors++;
    end

endmodule

bind frame_loader matrix_frame_sva i_sva (
    .clk           (clk),
    .reset         (reset),
    .write_active  (write_active),
    .access_toggle (access_toggle),
    .load_done     (load_done),
    .rd_en         (1'b0),
    .rd_valid      (1'b0)
);

bind frame_buffer matrix_frame_sva i_sva (
    .clk           (clk),
    .reset         (reset),
    .write_active  (write_active),
    .access_toggle (access_toggle),
    .load_done     (1'b0),
    .rd_en         (rd_en),
    .rd_valid      (rd_valid)
);

// File: matrix_frame_top.sv
/* LED matrix frame store */

`timescale 1ns/1ps

module matrix_frame_top
    import matrix_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  byte_t byte_in,
    input  logic  byte_valid,
    input  logic  rd_en,
    input  row_t  rd_row,
    input  col_t  rd_column,
    input  pix_t  rd_pixel,
    output byte_t rd_data,
    output logic  rd_valid,
    output logic  busy,
    output logic  frame_done,
    output logic  bad_cmd
);

    // decoder to loader.
    logic  load_enable;
    byte_t load_data;
    logic  load_done;

    // loader to buffer.
    row_t  row;
    col_t  column;
    pix_t  pixel;
    byte_t wr_data;
    logic  write_active;
    logic  access_toggle;

    cmd_decoder i_decoder (
        .clk         (clk),
        .reset       (reset),
        .byte_in     (byte_in),
        .byte_valid  (byte_valid),
        .load_done   (load_done),
        .load_enable (load_enable),
        .load_data   (load_data),
        .busy        (busy),
        .frame_done  (frame_done),
        .bad_cmd     (bad_cmd)
    );

    frame_loader i_loader (
        .clk           (clk),
        .reset         (reset),
        .load_enable   (load_enable),
        .load_data     (load_data),
        .row           (row),
        .column        (column),
        .pixel         (pixel),
        .wr_data       (wr_data),
        .write_active  (write_active),
        .access_toggle (access_toggle),
        .load_done     (load_done)
    );

    frame_buffer i_buffer (
        .clk           (clk),
        .reset         (reset),
        .row           (row),
        .column        (column),
        .pixel         (pixel),
        .wr_data       (wr_data),
        .write_active  (write_active),
        .access_toggle (access_toggle),
        .rd_en         (rd_en),
        .rd_row        (rd_row),
        .rd_column     (rd_column),
        .rd_pixel      (rd_pixel),
        .rd_data       (rd_data),
        .rd_valid      (rd_valid)
    );

endmodule

// File: matrix_pkg.sv
/* LED matrix types */

`include "matrix_defs.svh"

package matrix_pkg;

    // ====================
    // data and coordinates.
    // ====================
    typedef logic [7:0] byte_t;

    typedef logic [`MATRIX_ROW_BITS-1:0] row_t;
    typedef logic [`MATRIX_COL_BITS-1:0] col_t;
    typedef logic [`MATRIX_PIX_BITS-1:0] pix_t;

    // linear byte address into the frame RAM.
    typedef logic [`MATRIX_ADDR_BITS-1:0] ram_addr_t;

    // ====================
    // state machines.
    // ====================
    typedef enum logic [0:0] {
        DEC_IDLE,
        DEC_PAYLOAD
    } decoder_state_t;

    typedef enum logic [1:0] {
        LOAD_PRIME,
        LOAD_STREAM,
        LOAD_DONE
    } loader_state_t;

endpackage

// File: project.f
+incdir+.
matrix_pkg.sv
cmd_decoder.sv
frame_loader.sv
frame_buffer.sv
matrix_frame_top.sv
matrix_frame_sva.sv
tb_matrix_frame.sv

// File: tb_matrix_frame.sv
/* LED matrix frame store testbench */

`timescale 1ns/1ps

`include "matrix_defs.svh"

module tb_matrix_frame
    import matrix_pkg::*;
;

    localparam int FRAME = `MATRIX_FRAME_BYTES;
    // about three times the length of all tests.
    localparam int CYCLE_LIMIT = 2000;

    logic  clk;
    logic  reset;
    byte_t byte_in;
    logic  byte_valid;
    logic  rd_en;
    row_t  rd_row;
    col_t  rd_column;
    pix_t  rd_pixel;
    byte_t rd_data;
    logic  rd_valid;
    logic  busy;
    logic  frame_done;
    logic  bad_cmd;

    byte_t frame_data [FRAME];
    byte_t exp_mem [FRAME];
    int    error_count = 0;
    int    check_count = 0;
    int    test_count  = 0;
    int    cycle_count = 0;

    matrix_frame_top i_dut (
        .clk        (clk),
        .reset      (reset),
        .byte_in    (byte_in),
        .byte_valid (byte_valid),
        .rd_en      (rd_en),
        .rd_row     (rd_row),
        .rd_column  (rd_column),
        .rd_pixel   (rd_pixel),
        .rd_data    (rd_data),
        .rd_valid   (rd_valid),
        .busy       (busy),
        .frame_done (frame_done),
        .bad_cmd    (bad_cmd)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run stopped after %0d cycles", cycle_count);
            $display("Errors found");
            $finish;
        end
    end

    // ====================
    // compare tasks
    // ====================
    task automatic compare_byte(string what, byte_t actual, byte_t expected);
        check_count++;
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, actual, expected);
            error_count++;
        end
    endtask

    task automatic compare_flag(string what, logic actual, logic expected);
        check_count++;
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s got %b expected %b", $time, what, actual, expected);
            error_count++;
        end
    endtask

    // ====================
    // drivers
    // ====================
    task automatic send_byte(byte_t value);
        @(negedge clk);
        byte_in    = value;
        byte_valid = 1'b1;
    endtask

    task automatic bus_idle(int cycles);
        repeat (cycles) begin
            @(negedge clk);
            byte_valid = 1'b0;
        end
    endtask

    // linear address back to row, column and colour byte.
    task automatic point_read(int addr);
        rd_en     = 1'b1;
        rd_row    = row_t'(addr / (`MATRIX_WIDTH * `MATRIX_BPP));
        rd_column = col_t'((addr / `MATRIX_BPP) % `MATRIX_WIDTH);
        rd_pixel  = pix_t'(addr % `MATRIX_BPP);
    endtask

    task automatic fill_random();
        for (int k = 0; k < FRAME; k++) begin
            frame_data[k] = byte_t'($urandom);
        end
    endtask

    task automatic wait_frame_done();
        int waited;
        waited = 0;
        while (frame_done !== 1'b1 && waited < 16) begin
            @(negedge clk);
            waited++;
        end
        if (frame_done !== 1'b1) begin
            $display("frame_done never pulsed after the last payload byte");
            error_count++;
        end else begin
            compare_flag("busy at frame_done", busy, 1'b0);
            @(negedge clk);
            compare_flag("frame_done width", frame_done, 1'b0);
        end
    endtask

    // payload byte k lands at address FRAME-1-k.
    task automatic send_frame(int max_gap);
        send_byte(`CMD_LOAD_FRAME);
        for (int k = 0; k < FRAME; k++) begin
            if (max_gap > 0) begin
                bus_idle($urandom_range(max_gap, 0));
            end
            send_byte(frame_data[k]);
        end
        compare_flag("busy during load", busy, 1'b1);
        bus_idle(1);
        wait_frame_done();
        for (int k = 0; k < FRAME; k++) begin
            exp_mem[FRAME - 1 - k] = frame_data[k];
        end
    endtask

    // one read per cycle, checked one cycle later.
    task automatic check_frame(string what);
        for (int a = 0; a <= FRAME; a++) begin
            @(negedge clk);
            if (a > 0) begin
                compare_flag({what, " rd_valid"}, rd_valid, 1'b1);
                compare_byte($sformatf("%s addr %0d", what, a - 1), rd_data, exp_mem[a - 1]);
            end
            if (a < FRAME) begin
                point_read(a);
            end else begin
                rd_en = 1'b0;
            end
        end
    endtask

    task automatic finish_test(string name, int errors_before);
        test_count++;
        $display("test %-16s %s, %0d mismatches", name,
                 (error_count == errors_before) ? "passed" : "FAILED",
                 error_count - errors_before);
    endtask

    // ====================
    // tests
    // ====================
    task automatic test_reset_state();
        int errs;
        errs = error_count;
        compare_flag("busy after reset", busy, 1'b0);
        compare_flag("frame_done after reset", frame_done, 1'b0);
        compare_flag("bad_cmd after reset", bad_cmd, 1'b0);
        compare_flag("rd_valid after reset", rd_valid, 1'b0);
        point_read(0);
        @(negedge clk);
        compare_flag("rd_valid one cycle after rd_en", rd_valid, 1'b1);
        rd_en = 1'b0;
        @(negedge clk);
        compare_flag("rd_valid after read", rd_valid, 1'b0);
        finish_test("reset_state", errs);
    endtask

    task automatic test_back_to_back();
        int errs;
        errs = error_count;
        fill_random();
        send_frame(0);
        check_frame("back to back");
        finish_test("back_to_back", errs);
    endtask

    task automatic test_gapped();
        int errs;
        errs = error_count;
        fill_random();
        send_frame(3);
        check_frame("gapped");
        finish_test("gapped", errs);
    endtask

    task automatic test_bad_command();
        int errs;
        errs = error_count;
        send_byte(byte_t'($urandom_range(255, 2)));
        bus_idle(1);
        compare_flag("bad_cmd pulse", bad_cmd, 1'b1);
        compare_flag("busy on bad command", busy, 1'b0);
        bus_idle(1);
        compare_flag("bad_cmd width", bad_cmd, 1'b0);
        compare_flag("busy after bad command", busy, 1'b0);
        check_frame("after bad command");
        finish_test("bad_command", errs);
    endtask

    task automatic test_two_frames();
        byte_t first_frame [FRAME];
        int    errs;
        errs = error_count;
        fill_random();
        send_frame(0);
        first_frame = frame_data;
        fill_random();
        // every byte differs so a missed write shows up.
        for (int k = 0; k < FRAME; k++) begin
            if (frame_data[k] == first_frame[k]) begin
                frame_data[k] = ~first_frame[k];
            end
        end
        send_frame(0);
        check_frame("second frame");
        finish_test("two_frames", errs);
    endtask

    task automatic test_read_during_load();
        int errs;
        int done_seen;
        errs      = error_count;
        done_seen = 0;
        fill_random();
        send_byte(`CMD_LOAD_FRAME);
        // byte i goes out at step i and is read back at step i+4.
        for (int i = 0; i < FRAME + 5; i++) begin
            @(negedge clk);
            if (frame_done === 1'b1) begin
                done_seen++;
            end
            if (i > 4) begin
                compare_flag("early read rd_valid", rd_valid, 1'b1);
                compare_byte($sformatf("early read of byte %0d", i - 5), rd_data,
                             frame_data[i - 5]);
            end
            byte_valid = (i < FRAME);
            if (i < FRAME) begin
                byte_in = frame_data[i];
            end
            if (i >= 4 && i < FRAME + 4) begin
                point_read(FRAME - 1 - (i - 4));
            end else begin
                rd_en = 1'b0;
            end
        end
        compare_flag("single frame_done during load", done_seen == 1, 1'b1);
        compare_flag("busy after load", busy, 1'b0);
        for (int k = 0; k < FRAME; k++) begin
            exp_mem[FRAME - 1 - k] = frame_data[k];
        end
        check_frame("after early reads");
        finish_test("read_during_load", errs);
    endtask

    // ====================
    // main sequence
    // ====================
    initial begin
        int total;
        void'($urandom(14380));
        clk        = 1'b0;
        reset      = 1'b1;
        byte_in    = '0;
        byte_valid = 1'b0;
        rd_en      = 1'b0;
        rd_row     = '0;
        rd_column  = '0;
        rd_pixel   = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        test_reset_state();
        test_back_to_back();
        test_gapped();
        test_bad_command();
        test_two_frames();
        test_read_during_load();

        total = error_count + i_dut.i_loader.i_sva.assert_errors
              + i_dut.i_buffer.i_sva.assert_errors;
        $display("%0d tests, %0d checks, %0d mismatches, %0d assertion failures",
                 test_count, check_count, error_count, total - error_count);
        if (total == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
